// File: common/coreMem_config.svh
`ifndef CORE_MEM_CONFIG_SVH
`define CORE_MEM_CONFIG_SVH

// delay line timing, expressed in clock cycles

// first delay phase, from sync until the inhibit pattern is taken
`define CORE_MEM_T1_CYCLES 25

// second delay phase, from the inhibit latch until the read or store pulse
`define CORE_MEM_T2_CYCLES 15

// array geometry

// number of words in one core module
`define CORE_MEM_WORDS 4096

// bits per syllable; a word holds two of them
`define CORE_MEM_SYL_BITS 14

`endif

// File: common/coreMemPkg.sv
`include "coreMem_config.svh"

package coreMemPkg;

    // word address, wide enough for every word of the module
    typedef logic [$clog2(`CORE_MEM_WORDS)-1:0] memAddrT;

    typedef logic [`CORE_MEM_SYL_BITS-1:0] syllableT;

    // high syllable in the upper bits, low syllable in the lower bits
    typedef logic [2*`CORE_MEM_SYL_BITS-1:0] memWordT;

    // one group of eight active-low coordinate drive lines, line n on bit n
    typedef logic [7:0] driveGroupT;

    // the octal digit selected by one drive group
    typedef logic [2:0] octalDigitT;

    // the syllable-0 line high selects the low syllable
    typedef enum logic {
        SYL_HIGH = 1'b0,
        SYL_LOW  = 1'b1
    } sylSelT;

    typedef enum logic {
        CYC_STORE = 1'b0,
        CYC_READ  = 1'b1
    } cycleKindT;

    typedef enum logic [1:0] {
        SEQ_IDLE   = 2'd0,
        SEQ_PHASE1 = 2'd1,
        SEQ_PHASE2 = 2'd2,
        SEQ_FIRE   = 2'd3
    } seqStateT;

    // everything the array needs to know about the cycle, taken at sync
    typedef struct packed {
        memAddrT   addr;
        cycleKindT kind;
        sylSelT    syl;
    } memRequestT;

endpackage

// File: coreMemory/coordDecoder.sv
module coordDecoder
    import coreMemPkg::*;
(
    input  driveGroupT driveX0,
    input  driveGroupT driveY0,
    input  driveGroupT driveX1,
    input  driveGroupT driveY1,
    output memAddrT    decodedAddr
);

    octalDigitT digitX0;
    octalDigitT digitY0;
    octalDigitT digitX1;
    octalDigitT digitY1;

    // exactly one line pulled low names the digit, anything else reads as 0
    function automatic octalDigitT groupToDigit(input driveGroupT group);
        octalDigitT digit;
        case (group)
            8'b1111_1110: digit = 3'o0;
            8'b1111_1101: digit = 3'o1;
            8'b1111_1011: digit = 3'o2;
            8'b1111_0111: digit = 3'o3;
            8'b1110_1111: digit = 3'o4;
            8'b1101_1111: digit = 3'o5;
            8'b1011_1111: digit = 3'o6;
            8'b0111_1111: digit = 3'o7;
            default:      digit = 3'o0;
        endcase
        return digit;
    endfunction

    assign digitX0 = groupToDigit(driveX0);
    assign digitY0 = groupToDigit(driveY0);
    assign digitX1 = groupToDigit(driveX1);
    assign digitY1 = groupToDigit(driveY1);

    // the X1 digit is split, its top bit lands on the address msb
    assign decodedAddr = {
        digitX1[2],
        digitY1,
        digitX1[1:0],
        digitY0,
        digitX0
    };

endmodule

// File: coreMemory/cycleSequencer.sv
`include "coreMem_config.svh"

module cycleSequencer
    import coreMemPkg::*;
(
    input  logic       clk,
    input  logic       arstN,
    input  logic       sync,
    input  logic       readMode,
    input  sylSelT     sylSel,
    input  memAddrT    decodedAddr,
    output memRequestT request,
    output logic       latchInhibit,
    output logic       storePulse,
    output logic       readPulse,
    output logic       driveActive,
    output logic       busy
);

    localparam int CntMax = (`CORE_MEM_T1_CYCLES > `CORE_MEM_T2_CYCLES) ?
                            `CORE_MEM_T1_CYCLES : `CORE_MEM_T2_CYCLES;
    localparam int CntWidth = $clog2(CntMax + 1);

    seqStateT            state;
    logic [CntWidth-1:0] phaseCnt;
    logic                startCycle;

    // a sync seen mid-cycle is simply lost
    assign startCycle = sync && (state == SEQ_IDLE);

    always_ff @(posedge clk) begin
        if (startCycle) begin
            request.addr <= decodedAddr;
            request.kind <= readMode ? CYC_READ : CYC_STORE;
            request.syl  <= sylSel;
        end
    end

    // phaseCnt is loaded with length-1 on entry, the phase ends when it hits 0
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state        <= SEQ_IDLE;
            phaseCnt     <= '0;
            latchInhibit <= 1'b0;
        end else begin
            latchInhibit <= 1'b0;
            case (state)
                SEQ_IDLE: begin
                    if (startCycle) begin
                        state    <= SEQ_PHASE1;
                        phaseCnt <= CntWidth'(`CORE_MEM_T1_CYCLES - 1);
                    end
                end
                SEQ_PHASE1: begin
                    if (phaseCnt == '0) begin
                        state        <= SEQ_PHASE2;
                        phaseCnt     <= CntWidth'(`CORE_MEM_T2_CYCLES - 1);
                        latchInhibit <= 1'b1;
                    end else begin
                        phaseCnt <= phaseCnt - 1'b1;
                    end
                end
                SEQ_PHASE2: begin
                    if (phaseCnt == '0) begin
                        state <= SEQ_FIRE;
                    end else begin
                        phaseCnt <= phaseCnt - 1'b1;
                    end
                end
                SEQ_FIRE: begin
                    state <= SEQ_IDLE;
                end
                default: begin
                    state <= SEQ_IDLE;
                end
            endcase
        end
    end

    assign storePulse  = (state == SEQ_FIRE) && (request.kind == CYC_STORE);
    assign readPulse   = (state == SEQ_FIRE) && (request.kind == CYC_READ);

    // both X and Y drivers fire on either kind of cycle
    assign driveActive = (state == SEQ_FIRE);
    assign busy        = (state != SEQ_IDLE);

endmodule

// File: coreMemory/inhibitDriver.sv
module inhibitDriver
    import coreMemPkg::*;
(
    input  logic     clk,
    input  logic     arstN,
    input  logic     latchInhibit,
    input  logic     selBufA,
    input  logic     selBufB,
    input  syllableT bufA,
    input  syllableT bufB,
    output syllableT inhibitWord
);

    syllableT gatedA;
    syllableT gatedB;

    // each buffer register only contributes when its select level is up
    assign gatedA = selBufA ? bufA : '0;
    assign gatedB = selBufB ? bufB : '0;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            inhibitWord <= '0;
        end else if (latchInhibit) begin
            inhibitWord <= gatedA | gatedB;
        end
    end

endmodule

// File: coreMemory/coreArray.sv
`include "coreMem_config.svh"

module coreArray
    import coreMemPkg::*;
(
    input  logic       clk,
    input  logic       arstN,
    input  logic       storePulse,
    input  logic       readPulse,
    input  logic       senseInhibit,
    input  memRequestT request,
    input  syllableT   inhibitWord,
    output syllableT   senseData,
    output logic       senseValid
);

    localparam int SylBits = `CORE_MEM_SYL_BITS;

    memWordT  core [`CORE_MEM_WORDS];
    memWordT  coreWord;
    syllableT highSyl;
    syllableT lowSyl;
    syllableT selSyl;

    assign coreWord = core[request.addr];
    assign highSyl  = coreWord[2*SylBits-1:SylBits];
    assign lowSyl   = coreWord[SylBits-1:0];
    assign selSyl   = (request.syl == SYL_LOW) ? lowSyl : highSyl;

    // only the addressed syllable is rewritten, its partner goes back as read
    always_ff @(posedge clk) begin
        if (storePulse) begin
            if (request.syl == SYL_LOW) begin
                core[request.addr] <= {highSyl, inhibitWord};
            end else begin
                core[request.addr] <= {inhibitWord, lowSyl};
            end
        end
    end

    // sense amplifiers, strobed by the read pulse unless inhibited
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            senseData  <= '0;
            senseValid <= 1'b0;
        end else if (readPulse && !senseInhibit) begin
            senseData  <= selSyl;
            senseValid <= 1'b1;
        end else begin
            senseData  <= '0;
            senseValid <= 1'b0;
        end
    end

endmodule

// File: hdl/coreMemTop.sv
module coreMemTop
    import coreMemPkg::*;
(
    input  logic       clk,
    input  logic       arstN,
    input  driveGroupT driveX0,
    input  driveGroupT driveY0,
    input  driveGroupT driveX1,
    input  driveGroupT driveY1,
    input  logic       readMode,
    input  sylSelT     sylSel,
    input  logic       selBufA,
    input  logic       selBufB,
    input  syllableT   bufA,
    input  syllableT   bufB,
    input  logic       senseInhibit,
    input  logic       sync,
    output syllableT   senseData,
    output logic       senseValid,
    output logic       driveActive,
    output logic       busy
);

    memAddrT    decodedAddr;
    memRequestT request;
    logic       latchInhibit;
    logic       storePulse;
    logic       readPulse;
    syllableT   inhibitWord;

    coordDecoder uDecoder (
        .driveX0     (driveX0),
        .driveY0     (driveY0),
        .driveX1     (driveX1),
        .driveY1     (driveY1),
        .decodedAddr (decodedAddr)
    );

    cycleSequencer uSequencer (
        .clk          (clk),
        .arstN        (arstN),
        .sync         (sync),
        .readMode     (readMode),
        .sylSel       (sylSel),
        .decodedAddr  (decodedAddr),
        .request      (request),
        .latchInhibit (latchInhibit),
        .storePulse   (storePulse),
        .readPulse    (readPulse),
        .driveActive  (driveActive),
        .busy         (busy)
    );

    inhibitDriver uInhibit (
        .clk          (clk),
        .arstN        (arstN),
        .latchInhibit (latchInhibit),
        .selBufA      (selBufA),
        .selBufB      (selBufB),
        .bufA         (bufA),
        .bufB         (bufB),
        .inhibitWord  (inhibitWord)
    );

    coreArray uArray (
        .clk          (clk),
        .arstN        (arstN),
        .storePulse   (storePulse),
        .readPulse    (readPulse),
        .senseInhibit (senseInhibit),
        .request      (request),
        .inhibitWord  (inhibitWord),
        .senseData    (senseData),
        .senseValid   (senseValid)
    );

endmodule

// File: sim/coreMem_properties.sv
module coreMemProperties (
    input logic clk,
    input logic arstN,
    input logic storePulse,
    input logic readPulse,
    input logic driveActive,
    input logic busy
);
    timeunit 1ns;
    timeprecision 1ps;

    // both fire pulses come out of the one SEQ_FIRE state
    assertPulseExclusive: assert property (
        @(posedge clk) disable iff (!arstN) !(storePulse && readPulse)
    ) else $error("store pulse and read pulse are high together");

    assertDriveActive: assert property (
        @(posedge clk) disable iff (!arstN) driveActive == (storePulse || readPulse)
    ) else $error("driveActive does not match the fire pulses");

    // the cycle ends on the edge right after the fire pulse
    assertBusyFalls: assert property (
        @(posedge clk) disable iff (!arstN) (storePulse || readPulse) |-> busy ##1 !busy
    ) else $error("busy did not fall one cycle after the fire pulse");

endmodule

bind cycleSequencer coreMemProperties props0 (
    .clk         (clk),
    .arstN       (arstN),
    .storePulse  (storePulse),
    .readPulse   (readPulse),
    .driveActive (driveActive),
    .busy        (busy)
);

// File: sim/coreMemTb.sv
`include "coreMem_config.svh"

module coreMemTb
    import coreMemPkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    // driveActive shows up just after this edge, counted from the edge that samples sync
    localparam int FireIdx = `CORE_MEM_T1_CYCLES + `CORE_MEM_T2_CYCLES;
    localparam int TimeoutCycles = FireIdx + 20;

    logic       clk;
    logic       arstN;
    driveGroupT driveX0;
    driveGroupT driveY0;
    driveGroupT driveX1;
    driveGroupT driveY1;
    logic       readMode;
    sylSelT     sylSel;
    logic       selBufA;
    logic       selBufB;
    syllableT   bufA;
    syllableT   bufB;
    logic       senseInhibit;
    logic       sync;
    syllableT   senseData;
    logic       senseValid;
    logic       driveActive;
    logic       busy;

    // key is address times two plus one for the low syllable
    syllableT modelMem [int];

    coreMemTop dut0 (
        .clk          (clk),
        .arstN        (arstN),
        .driveX0      (driveX0),
        .driveY0      (driveY0),
        .driveX1      (driveX1),
        .driveY1      (driveY1),
        .readMode     (readMode),
        .sylSel       (sylSel),
        .selBufA      (selBufA),
        .selBufB      (selBufB),
        .bufA         (bufA),
        .bufB         (bufB),
        .senseInhibit (senseInhibit),
        .sync         (sync),
        .senseData    (senseData),
        .senseValid   (senseValid),
        .driveActive  (driveActive),
        .busy         (busy)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    task automatic failRun(input string what);
        $display("%s", what);
        $display("TESTS FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic checkSyllable(input string name, input syllableT expected,
                                 input syllableT actual);
        if (actual !== expected) begin
            failRun($sformatf("FAIL %s expected %h actual %h", name, expected, actual));
        end
    endtask

    task automatic checkFlag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            failRun($sformatf("FAIL %s expected %b actual %b", name, expected, actual));
        end
    endtask

    task automatic checkCount(input string name, input int expected, input int actual);
        if (actual != expected) begin
            failRun($sformatf("FAIL %s expected %0d actual %0d", name, expected, actual));
        end
    endtask

    // one full memory cycle, started 5 ns after a rising edge
    task automatic runCycle(
        input string      name,
        input memAddrT    addr,
        input logic [3:0] badMask,
        input logic       isRead,
        input sylSelT     syl,
        input logic       useA,
        input logic       useB,
        input syllableT   valA,
        input syllableT   valB,
        input logic       inhibit,
        input logic       extraSync
    );
        octalDigitT digits [4];
        driveGroupT groups [4];
        memAddrT    effAddr;
        int         g;
        int         key;
        int         idx;
        int         endIdx;
        int         fireIdx;
        int         fireCount;
        int         validCount;
        logic       done;
        logic       validAtEnd;
        syllableT   dataAtEnd;
        digits[0] = addr[2:0];
        digits[1] = addr[5:3];
        digits[2] = {addr[11], addr[7:6]};
        digits[3] = addr[10:8];
        for (g = 0; g < 4; g++) begin
            if (badMask[g]) begin
                groups[g] = driveGroupT'($urandom);
                if ($countones(~groups[g]) == 1) begin
                    groups[g] = 8'hff;
                end
                digits[g] = 3'o0;
            end else begin
                groups[g] = ~(8'h01 << digits[g]);
            end
        end
        effAddr = {digits[2][2], digits[3], digits[2][1:0], digits[1], digits[0]};
        key = int'(effAddr) * 2 + ((syl == SYL_LOW) ? 1 : 0);

        @(posedge clk);
        #5;
        driveX0      = groups[0];
        driveY0      = groups[1];
        driveX1      = groups[2];
        driveY1      = groups[3];
        readMode     = isRead;
        sylSel       = syl;
        selBufA      = useA;
        selBufB      = useB;
        bufA         = valA;
        bufB         = valB;
        senseInhibit = inhibit;
        sync         = 1'b1;

        // idx 0 is the edge that samples sync
        idx = 0;
        endIdx = -1;
        fireIdx = -1;
        fireCount = 0;
        validCount = 0;
        done = 1'b0;
        while (!done) begin
            @(posedge clk);
            #1;
            if (driveActive) begin
                fireCount++;
                if (fireIdx < 0) begin
                    fireIdx = idx;
                end
            end
            if (senseValid) begin
                validCount++;
            end
            if (!busy) begin
                done = 1'b1;
                endIdx = idx;
                dataAtEnd = senseData;
                validAtEnd = senseValid;
            end else if (idx > TimeoutCycles) begin
                failRun({name, ": busy did not fall within the timeout"});
            end
            #4;
            sync = extraSync && (idx == 3);
            idx++;
        end

        checkCount({name, " fire edge"}, FireIdx, fireIdx);
        checkCount({name, " fire count"}, 1, fireCount);
        checkCount({name, " busy length"}, FireIdx + 1, endIdx);
        if (isRead && !inhibit) begin
            checkFlag({name, " senseValid"}, 1'b1, validAtEnd);
            checkCount({name, " valid count"}, 1, validCount);
            if (modelMem.exists(key)) begin
                checkSyllable({name, " senseData"}, modelMem[key], dataAtEnd);
            end
        end else begin
            checkFlag({name, " senseValid"}, 1'b0, validAtEnd);
            checkCount({name, " valid count"}, 0, validCount);
            checkSyllable({name, " senseData"}, '0, dataAtEnd);
        end
        if (!isRead) begin
            modelMem[key] = (useA ? valA : syllableT'(0)) | (useB ? valB : syllableT'(0));
        end

        @(posedge clk);
        #1;
        checkFlag({name, " senseValid after"}, 1'b0, senseValid);
        checkFlag({name, " driveActive after"}, 1'b0, driveActive);
        checkFlag({name, " busy after"}, 1'b0, busy);
    endtask

    initial begin
        memAddrT    addr;
        memAddrT    pool [8];
        syllableT   valA;
        syllableT   valB;
        logic [3:0] badMask;
        int         n;
        void'($urandom(32'hb69f0931));
        arstN = 1'b0;
        sync = 1'b0;
        driveX0 = 8'hff;
        driveY0 = 8'hff;
        driveX1 = 8'hff;
        driveY1 = 8'hff;
        readMode = 1'b0;
        sylSel = SYL_HIGH;
        selBufA = 1'b0;
        selBufB = 1'b0;
        bufA = '0;
        bufB = '0;
        senseInhibit = 1'b0;
        repeat (10) @(posedge clk);
        #5;
        arstN = 1'b1;
        checkFlag("reset busy", 1'b0, busy);
        checkFlag("reset senseValid", 1'b0, senseValid);
        checkFlag("reset driveActive", 1'b0, driveActive);
        checkSyllable("reset senseData", '0, senseData);

        addr = memAddrT'($urandom);
        valA = syllableT'($urandom);
        valB = syllableT'($urandom);
        runCycle("store low A", addr, 4'h0, 1'b0, SYL_LOW, 1'b1, 1'b0, valA, valB, 1'b0, 1'b0);
        runCycle("read low", addr, 4'h0, 1'b1, SYL_LOW, 1'b0, 1'b0, '0, '0, 1'b0, 1'b0);
        runCycle("store high B", addr, 4'h0, 1'b0, SYL_HIGH, 1'b0, 1'b1, valA, valB, 1'b0, 1'b0);
        runCycle("read low kept", addr, 4'h0, 1'b1, SYL_LOW, 1'b0, 1'b0, '0, '0, 1'b0, 1'b0);
        runCycle("read high", addr, 4'h0, 1'b1, SYL_HIGH, 1'b0, 1'b0, '0, '0, 1'b0, 1'b0);
        runCycle("store high AB", addr, 4'h0, 1'b0, SYL_HIGH, 1'b1, 1'b1, valA, valB, 1'b0, 1'b0);
        runCycle("read high AB", addr, 4'h0, 1'b1, SYL_HIGH, 1'b0, 1'b0, '0, '0, 1'b0, 1'b0);
        runCycle("store low none", addr, 4'h0, 1'b0, SYL_LOW, 1'b0, 1'b0, valA, valB, 1'b0, 1'b0);
        runCycle("read low none", addr, 4'h0, 1'b1, SYL_LOW, 1'b0, 1'b0, '0, '0, 1'b0, 1'b0);
        runCycle("read inhibited", addr, 4'h0, 1'b1, SYL_HIGH, 1'b0, 1'b0, '0, '0, 1'b1, 1'b0);
        runCycle("read after inhibit", addr, 4'h0, 1'b1, SYL_HIGH, 1'b0, 1'b0, '0, '0, 1'b0, 1'b0);
        runCycle("sync while busy", addr, 4'h0, 1'b1, SYL_HIGH, 1'b0, 1'b0, '0, '0, 1'b0, 1'b1);
        runCycle("store garbled", addr, 4'hf, 1'b0, SYL_LOW, 1'b1, 1'b0, valB, valA, 1'b0, 1'b0);
        runCycle("read digit zero", '0, 4'h0, 1'b1, SYL_LOW, 1'b0, 1'b0, '0, '0, 1'b0, 1'b0);

        // a small address pool so that random reads hit stored syllables
        for (n = 0; n < 8; n++) begin
            pool[n] = memAddrT'($urandom);
        end
        for (n = 0; n < 300; n++) begin
            addr = pool[$urandom_range(0, 7)];
            badMask = ($urandom_range(0, 7) == 0) ? 4'($urandom) : 4'h0;
            runCycle($sformatf("random step %0d", n), addr, badMask, 1'($urandom),
                     sylSelT'($urandom_range(0, 1)), 1'($urandom), 1'($urandom),
                     syllableT'($urandom), syllableT'($urandom),
                     ($urandom_range(0, 4) == 0), ($urandom_range(0, 3) == 0));
        end

        $display("TESTS PASSED");
        $finish;
    end

endmodule

// File: coreMemory.f
+incdir+common
common/coreMemPkg.sv
coreMemory/coordDecoder.sv
coreMemory/cycleSequencer.sv
coreMemory/inhibitDriver.sv
coreMemory/coreArray.sv
hdl/coreMemTop.sv
sim/coreMem_properties.sv
sim/coreMemTb.sv
